/* wb_config.svh */
// Constants for the writeback stage: widths, reset PC, micro-op encodings
// and trap causes. Included by the package and by every unit module.
`ifndef WB_CONFIG_SVH
`define WB_CONFIG_SVH

`define XLEN              32
`define REG_ADDR_W        5
`define CSR_ADDR_W        12
`define CAUSE_W           6
`define UOP_W             5
`define FU_W              5
`define PC_RESET          32'h8000_0000

// ------------------------------
// One-hot functional-unit select bits
`define FU_ALU            0
`define FU_MUL            1
`define FU_LSU            2
`define FU_CFU            3
`define FU_CSR            4

// ------------------------------
// LSU micro-op: bit 0 signed, bits 2..1 size, bit 3 load, bit 4 store
`define LSU_SIGNED        0
`define LSU_BYTE          2'd1
`define LSU_HALF          2'd2
`define LSU_WORD          2'd3
`define LSU_LOAD          3
`define LSU_STORE         4

// CSR micro-op flag bits
`define CSR_READ          0
`define CSR_WRITE         1
`define CSR_SET           2
`define CSR_CLEAR         3

// CFU micro-op codes, anything else is a branch not taken
`define CFU_BRANCH_TAKEN  5'd1
`define CFU_JAL           5'd2
`define CFU_JALR          5'd3
`define CFU_ECALL         5'd4
`define CFU_EBREAK        5'd5
`define CFU_MRET          5'd6

// Trap causes
`define TRAP_BREAKPOINT   6'd3
`define TRAP_LOAD_ACCESS  6'd5
`define TRAP_STORE_ACCESS 6'd7
`define TRAP_ECALL_M      6'd11

`endif

/* wb_pkg.sv */
// Shared types of the writeback stage.
// Imported by the interface and the modules that use these types.
`include "wb_config.svh"

package wb_pkg;

    // ------------------------------
    // Vector types
    typedef logic [`XLEN-1:0]       xlen_t;      // Data word
    typedef logic [`REG_ADDR_W-1:0] reg_addr_t;  // GPR index
    typedef logic [`CSR_ADDR_W-1:0] csr_addr_t;  // CSR address
    typedef logic [`UOP_W-1:0]      uop_t;       // Micro-op
    typedef logic [`FU_W-1:0]       fu_sel_t;    // One-hot unit select
    typedef logic [`CAUSE_W-1:0]    cause_t;     // Trap cause
    typedef logic [1:0]             ilen_t;      // Instr size in halfwords

    // ------------------------------
    // Completion tracking while the stage is stalled
    // A unit moves to DONE once its side effect happened and
    // returns to PENDING when the instruction leaves the stage
    typedef enum logic {
        UNIT_PENDING,
        UNIT_DONE
    } unit_state_t;

endpackage

/* wb_op_if.sv */
// Instruction bundle handed from the writeback top to its units.
// The top drives it through the source side, each unit reads the unit side.
`timescale 1ns/1ns

interface wb_op_if
    import wb_pkg::*;
();

    xlen_t opr_a;      // Operand A
    xlen_t opr_b;      // Operand B, also the LSU address
    uop_t  uop;        // Micro-op of the accepted instruction
    logic  progress;   // Instruction leaves the stage this cycle

    // Per-unit selects, already qualified by s4_valid
    logic  sel_csr;
    logic  sel_cfu;
    logic  sel_lsu;

    modport source (
        output opr_a,
        output opr_b,
        output uop,
        output progress,
        output sel_csr,
        output sel_cfu,
        output sel_lsu
    );

    modport unit (
        input opr_a,
        input opr_b,
        input uop,
        input progress,
        input sel_csr,
        input sel_cfu,
        input sel_lsu
    );

endinterface

/* wb_csr_unit.sv */
// CSR access unit of the writeback stage.
// Issues one CSR access per instruction and writes read data back to the GPR.
`timescale 1ns/1ns
`include "wb_config.svh"

module wb_csr_unit
    import wb_pkg::*;
(
    input  logic       g_clk,
    input  logic       g_resetn,
    wb_op_if.unit      op,
    output logic       csr_en,
    output logic       csr_wr,
    output logic       csr_wr_set,
    output logic       csr_wr_clr,
    output csr_addr_t  csr_addr,
    output xlen_t      csr_wdata,
    input  xlen_t      csr_rdata,
    output logic       gpr_wen,
    output xlen_t      gpr_wdata
);

    unit_state_t state_q;
    logic        access;

    // Only the first cycle of an instruction touches the CSR file
    assign access = op.sel_csr && (state_q == UNIT_PENDING);

    assign csr_en     = access;
    assign csr_wr     = op.sel_csr && op.uop[`CSR_WRITE];
    assign csr_wr_set = op.sel_csr && op.uop[`CSR_SET];
    assign csr_wr_clr = op.sel_csr && op.uop[`CSR_CLEAR];
    assign csr_addr   = op.opr_b[`CSR_ADDR_W-1:0];
    assign csr_wdata  = op.opr_a;

    assign gpr_wen    = access && op.uop[`CSR_READ];  // Read value to rd
    assign gpr_wdata  = csr_rdata;

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            state_q <= UNIT_PENDING;
        end else if (op.progress) begin
            state_q <= UNIT_PENDING;    // Next instruction starts fresh
        end else if (access) begin
            state_q <= UNIT_DONE;
        end
    end

endmodule

/* wb_cfu_unit.sv */
// Control-flow unit of the writeback stage.
// Holds the PC, raises control-flow requests for jumps, system instructions
// and traps, picks the trap cause and writes the link value for JAL/JALR.
`timescale 1ns/1ns
`include "wb_config.svh"

module wb_cfu_unit
    import wb_pkg::*;
(
    input  logic   g_clk,
    input  logic   g_resetn,
    wb_op_if.unit  op,
    input  logic   s4_trap,
    input  ilen_t  s4_size,
    input  logic   lsu_trap,
    input  logic   lsu_trap_load,
    input  xlen_t  csr_mepc,
    input  xlen_t  csr_mtvec,
    output logic   cf_req,
    output xlen_t  cf_target,
    input  logic   cf_ack,
    output logic   busy,
    output logic   trap_cpu,
    output cause_t trap_cause,
    output xlen_t  trap_pc,
    output logic   exec_mret,
    output logic   gpr_wen,
    output xlen_t  gpr_wdata
);

    xlen_t       pc_q;
    xlen_t       next_pc;
    unit_state_t req_q;     // Request acknowledged, stage still stalled
    unit_state_t link_q;    // Link value already written
    logic        taken;
    logic        is_ecall;
    logic        is_ebreak;
    logic        is_mret;
    logic        is_link;
    logic        want_req;

    // ------------------------------
    // Decode
    assign is_link   = op.sel_cfu && (op.uop == `CFU_JAL || op.uop == `CFU_JALR);
    assign taken     = is_link || (op.sel_cfu && op.uop == `CFU_BRANCH_TAKEN);
    assign is_ecall  = op.sel_cfu && (op.uop == `CFU_ECALL);
    assign is_ebreak = op.sel_cfu && (op.uop == `CFU_EBREAK);
    assign is_mret   = op.sel_cfu && (op.uop == `CFU_MRET);

    assign trap_cpu  = is_ecall || is_ebreak || s4_trap || lsu_trap;
    assign want_req  = taken || is_mret || trap_cpu;

    // ------------------------------
    // Control-flow request
    assign cf_req    = want_req && (req_q == UNIT_PENDING);
    assign cf_target = trap_cpu ? csr_mtvec :
                       is_mret  ? csr_mepc  :
                                  op.opr_a;  // Branch or jump target
    assign busy      = cf_req && !cf_ack;
    assign exec_mret = is_mret && op.progress;

    // Most specific cause wins
    assign trap_cause = lsu_trap_load ? `TRAP_LOAD_ACCESS  :
                        lsu_trap      ? `TRAP_STORE_ACCESS :
                        is_ebreak     ? `TRAP_BREAKPOINT   :
                        is_ecall      ? `TRAP_ECALL_M      :
                                        op.opr_a[`CAUSE_W-1:0];

    // ------------------------------
    // PC and link value
    assign next_pc   = pc_q + {{(`XLEN-3){1'b0}}, s4_size, 1'b0};
    assign trap_pc   = pc_q;
    assign gpr_wen   = is_link && (link_q == UNIT_PENDING);
    assign gpr_wdata = next_pc;

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            pc_q <= `PC_RESET;
        end else if (cf_req && cf_ack) begin
            pc_q <= cf_target;
        end else if (op.progress) begin
            pc_q <= next_pc;
        end
    end

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            req_q  <= UNIT_PENDING;
            link_q <= UNIT_PENDING;
        end else if (op.progress) begin
            req_q  <= UNIT_PENDING;
            link_q <= UNIT_PENDING;
        end else begin
            if (cf_req && cf_ack) req_q <= UNIT_DONE;
            if (gpr_wen) link_q <= UNIT_DONE;    // First cycle write only
        end
    end

endmodule

/* wb_lsu_unit.sv */
// Load/store completion unit of the writeback stage.
// Acknowledges the data-memory response, aligns and extends load data,
// and flags a bus error so the control-flow unit can trap.
`timescale 1ns/1ns
`include "wb_config.svh"

module wb_lsu_unit
    import wb_pkg::*;
(
    input  logic   g_clk,
    input  logic   g_resetn,
    wb_op_if.unit  op,
    input  logic   dmem_recv,
    output logic   dmem_ack,
    input  logic   dmem_error,
    input  xlen_t  dmem_rdata,
    output logic   busy,
    output logic   lsu_trap,
    output logic   lsu_trap_load,
    output logic   gpr_wen,
    output xlen_t  gpr_wdata
);

    unit_state_t state_q;    // Response already taken
    logic        err_q;      // That response carried an error
    logic        expect_rsp;
    logic        rsp_now;
    logic        is_load;
    logic        is_signed;
    logic [1:0]  size;
    logic [1:0]  addr;
    logic [7:0]  byte_v;
    logic [15:0] half_v;

    assign is_load   = op.uop[`LSU_LOAD];
    assign is_signed = op.uop[`LSU_SIGNED];
    assign size      = op.uop[2:1];
    assign addr      = op.opr_b[1:0];

    // ------------------------------
    // Response handshake
    assign expect_rsp = op.sel_lsu && (state_q == UNIT_PENDING);
    assign dmem_ack   = expect_rsp;
    assign rsp_now    = expect_rsp && dmem_recv;
    assign busy       = expect_rsp && !dmem_recv;

    // Error stays visible until the trap request is acknowledged
    assign lsu_trap      = (rsp_now && dmem_error) ||
                           (op.sel_lsu && state_q == UNIT_DONE && err_q);
    assign lsu_trap_load = lsu_trap && is_load;

    assign gpr_wen = rsp_now && is_load && !dmem_error;

    // ------------------------------
    // Load alignment
    assign byte_v = dmem_rdata[{addr, 3'b000} +: 8];
    assign half_v = addr[1] ? dmem_rdata[31:16] : dmem_rdata[15:0];

    always_comb begin
        case (size)
            `LSU_BYTE: gpr_wdata = {{24{is_signed && byte_v[7]}}, byte_v};
            `LSU_HALF: gpr_wdata = {{16{is_signed && half_v[15]}}, half_v};
            default:   gpr_wdata = dmem_rdata;      // Full word
        endcase
    end

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            state_q <= UNIT_PENDING;
            err_q   <= 1'b0;
        end else if (op.progress) begin
            state_q <= UNIT_PENDING;
            err_q   <= 1'b0;
        end else if (rsp_now) begin
            state_q <= UNIT_DONE;
            err_q   <= dmem_error;
        end
    end

endmodule

/* wb_stage.sv */
// Writeback stage top level of a small RV32 core.
// Accepts one instruction per s4 handshake, drives the unit bundle,
// forms the stall and selects the single GPR write of the cycle.
`timescale 1ns/1ns
`include "wb_config.svh"

module wb_stage
    import wb_pkg::*;
(
    input  logic      g_clk,
    input  logic      g_resetn,
    input  logic      s4_valid,
    output logic      s4_busy,
    input  reg_addr_t s4_rd,
    input  xlen_t     s4_opr_a,
    input  xlen_t     s4_opr_b,
    input  uop_t      s4_uop,
    input  fu_sel_t   s4_fu,
    input  logic      s4_trap,
    input  ilen_t     s4_size,
    output logic      gpr_wen,
    output reg_addr_t gpr_rd,
    output xlen_t     gpr_wdata,
    output logic      trap_cpu,
    output cause_t    trap_cause,
    output xlen_t     trap_pc,
    output logic      exec_mret,
    input  xlen_t     csr_mepc,
    input  xlen_t     csr_mtvec,
    output logic      csr_en,
    output logic      csr_wr,
    output logic      csr_wr_set,
    output logic      csr_wr_clr,
    output csr_addr_t csr_addr,
    output xlen_t     csr_wdata,
    input  xlen_t     csr_rdata,
    output logic      cf_req,
    output xlen_t     cf_target,
    input  logic      cf_ack,
    output logic      hold_lsu_req,
    input  logic      dmem_recv,
    output logic      dmem_ack,
    input  logic      dmem_error,
    input  xlen_t     dmem_rdata
);

    wb_op_if op_if ();

    logic  cfu_busy;
    logic  lsu_busy;
    logic  lsu_trap;
    logic  lsu_trap_load;
    logic  alu_wen;
    logic  mul_wen;
    logic  csr_gpr_wen;
    logic  cfu_gpr_wen;
    logic  lsu_gpr_wen;
    xlen_t csr_gpr_wdata;
    xlen_t cfu_gpr_wdata;
    xlen_t lsu_gpr_wdata;

    // ------------------------------
    // Handshake and unit bundle
    assign s4_busy      = cfu_busy || lsu_busy;
    assign hold_lsu_req = cf_req || lsu_busy;    // No new memory requests yet

    assign op_if.opr_a    = s4_opr_a;
    assign op_if.opr_b    = s4_opr_b;
    assign op_if.uop      = s4_uop;
    assign op_if.progress = s4_valid && !s4_busy;
    assign op_if.sel_csr  = s4_valid && s4_fu[`FU_CSR];
    assign op_if.sel_cfu  = s4_valid && s4_fu[`FU_CFU];
    assign op_if.sel_lsu  = s4_valid && s4_fu[`FU_LSU];

    // ------------------------------
    // GPR write, at most one source per cycle
    assign alu_wen   = s4_valid && s4_fu[`FU_ALU];
    assign mul_wen   = s4_valid && s4_fu[`FU_MUL];
    assign gpr_rd    = s4_rd;
    assign gpr_wen   = !trap_cpu &&
                       (alu_wen || mul_wen || csr_gpr_wen || cfu_gpr_wen || lsu_gpr_wen);
    assign gpr_wdata = ({`XLEN{alu_wen || mul_wen}} & s4_opr_a)      |
                       ({`XLEN{csr_gpr_wen}}        & csr_gpr_wdata) |
                       ({`XLEN{cfu_gpr_wen}}        & cfu_gpr_wdata) |
                       ({`XLEN{lsu_gpr_wen}}        & lsu_gpr_wdata);

    wb_csr_unit u_csr (
        .g_clk      (g_clk),
        .g_resetn   (g_resetn),
        .op         (op_if),
        .csr_en     (csr_en),
        .csr_wr     (csr_wr),
        .csr_wr_set (csr_wr_set),
        .csr_wr_clr (csr_wr_clr),
        .csr_addr   (csr_addr),
        .csr_wdata  (csr_wdata),
        .csr_rdata  (csr_rdata),
        .gpr_wen    (csr_gpr_wen),
        .gpr_wdata  (csr_gpr_wdata)
    );

    wb_cfu_unit u_cfu (
        .g_clk         (g_clk),
        .g_resetn      (g_resetn),
        .op            (op_if),
        .s4_trap       (s4_trap && s4_valid),   // Decode trap of a live instr
        .s4_size       (s4_size),
        .lsu_trap      (lsu_trap),
        .lsu_trap_load (lsu_trap_load),
        .csr_mepc      (csr_mepc),
        .csr_mtvec     (csr_mtvec),
        .cf_req        (cf_req),
        .cf_target     (cf_target),
        .cf_ack        (cf_ack),
        .busy          (cfu_busy),
        .trap_cpu      (trap_cpu),
        .trap_cause    (trap_cause),
        .trap_pc       (trap_pc),
        .exec_mret     (exec_mret),
        .gpr_wen       (cfu_gpr_wen),
        .gpr_wdata     (cfu_gpr_wdata)
    );

    wb_lsu_unit u_lsu (
        .g_clk         (g_clk),
        .g_resetn      (g_resetn),
        .op            (op_if),
        .dmem_recv     (dmem_recv),
        .dmem_ack      (dmem_ack),
        .dmem_error    (dmem_error),
        .dmem_rdata    (dmem_rdata),
        .busy          (lsu_busy),
        .lsu_trap      (lsu_trap),
        .lsu_trap_load (lsu_trap_load),
        .gpr_wen       (lsu_gpr_wen),
        .gpr_wdata     (lsu_gpr_wdata)
    );

endmodule

/* tb_wb_stage.sv */
// Self-checking testbench for the writeback stage.
// Plays the execute stage, answers the control-flow and data-memory
// handshakes with random delays and checks results against a model PC.
`timescale 1ns/1ns
`include "wb_config.svh"

module tb_wb_stage
    import wb_pkg::*;
();

    localparam int TIMEOUT = 50;

    logic      g_clk;
    logic      g_resetn;
    logic      s4_valid, s4_busy, s4_trap;
    reg_addr_t s4_rd, gpr_rd;
    xlen_t     s4_opr_a, s4_opr_b, gpr_wdata, trap_pc;
    uop_t      s4_uop;
    fu_sel_t   s4_fu;
    ilen_t     s4_size;
    logic      gpr_wen, trap_cpu, exec_mret;
    cause_t    trap_cause;
    xlen_t     csr_mepc, csr_mtvec, csr_wdata, csr_rdata;
    logic      csr_en, csr_wr, csr_wr_set, csr_wr_clr;
    csr_addr_t csr_addr;
    logic      cf_req, cf_ack, hold_lsu_req;
    xlen_t     cf_target;
    logic      dmem_recv, dmem_ack, dmem_error;
    xlen_t     dmem_rdata;

    int        errors, tests, test_errs;
    logic      timed_out;
    xlen_t     model_pc;            // Reference PC
    xlen_t     rnd, a, b;
    int        ack, recv;
    uop_t      uop;
    logic [1:0] sz;

    // What the DUT did for the last instruction
    int        n_cyc, n_wen, n_csr_en, n_req, n_ack_cyc, n_mret;
    xlen_t     wdata_seen, target_seen, csr_wdata_seen, size_used;
    reg_addr_t rd_seen, rd_used;
    logic      trap_seen;
    cause_t    cause_seen;
    logic [2:0] csr_flags_seen;     // {clear, set, write}
    csr_addr_t csr_addr_seen;

    wb_stage u_dut (.*);

    always #10 g_clk = ~g_clk;

    // ------------------------------
    // Helpers
    task automatic check(input logic cond, input string msg);
        if (!timed_out) begin
            assert (cond) else begin
                $display("[ERROR] %0t ns: %s", $time, msg);
                errors++;
            end
        end
    endtask

    task automatic end_test(input string name);
        tests++;
        if (errors == test_errs)
            $display("[TEST] %-8s ok", name);
        else
            $display("[TEST] %-8s %0d error(s)", name, errors - test_errs);
        test_errs = errors;
    endtask

    function automatic fu_sel_t fu_bit(input int idx);
        return fu_sel_t'(32'd1 << idx);
    endfunction

    // Byte at lane addr[1:0], half at lane addr[1], then extend
    function automatic xlen_t load_value(input uop_t op, input xlen_t addr, input xlen_t data);
        xlen_t lane;
        logic  sgn;
        sgn = op[0];
        case (op[2:1])
            2'd1: begin
                lane = data >> {addr[1:0], 3'b000};
                return {{24{sgn & lane[7]}}, lane[7:0]};
            end
            2'd2: begin
                lane = data >> {addr[1], 4'b0000};
                return {{16{sgn & lane[15]}}, lane[15:0]};
            end
            default: return data;
        endcase
    endfunction

    task automatic idle_inputs();
        s4_valid  = 1'b0;
        s4_fu     = '0;     // No unit selected while idle
        s4_trap   = 1'b0;
        cf_ack    = 1'b0;
        dmem_recv = 1'b0;
    endtask

    task automatic step_pc();
        model_pc = model_pc + size_used + size_used;
    endtask

    // ------------------------------
    // Issue one instruction and follow it until progress
    // recv_at and ack_at give the dmem_recv and cf_ack cycles or -1 for none
    task automatic run_op(input fu_sel_t fu, input uop_t op, input xlen_t opa, input xlen_t opb,
                          input logic trap, input int recv_at, input int ack_at);
        int    cyc;
        logic  done;
        logic  lsu_wait;
        xlen_t r;
        if (timed_out) return;
        r         = $urandom();
        rd_used   = r[4:0];
        size_used = {30'd0, r[6:5]};
        s4_valid  = 1'b1;
        s4_fu     = fu;
        s4_uop    = op;
        s4_opr_a  = opa;
        s4_opr_b  = opb;
        s4_trap   = trap;
        s4_rd     = rd_used;
        s4_size   = size_used[1:0];
        n_wen = 0;
        n_csr_en = 0;
        n_req = 0;
        n_ack_cyc = 0;
        n_mret = 0;
        trap_seen = 1'b0;
        cause_seen = '0;
        target_seen = '0;
        wdata_seen = '0;
        rd_seen = '0;
        cyc = 0;
        done = 1'b0;
        while (!done) begin
            dmem_recv = (cyc == recv_at);
            cf_ack    = (ack_at >= 0) && (cyc >= ack_at);
            lsu_wait  = fu[`FU_LSU] && (cyc < recv_at);    // Memory response still due
            #1;
            if (cyc == 0) begin
                check(trap_pc == model_pc, "trap_pc differs from model PC");
                csr_flags_seen = {csr_wr_clr, csr_wr_set, csr_wr};
                csr_addr_seen  = csr_addr;
                csr_wdata_seen = csr_wdata;
            end
            if (gpr_wen) begin
                n_wen++;
                wdata_seen = gpr_wdata;
                rd_seen    = gpr_rd;
            end
            if (csr_en) n_csr_en++;
            if (!fu[`FU_CSR]) check(!csr_en, "csr_en high without a CSR instruction");
            if (!fu[`FU_LSU]) check(!dmem_ack, "dmem_ack high without a memory access");
            check(hold_lsu_req == (cf_req || lsu_wait),
                  "hold_lsu_req does not follow cf_req and the memory wait");
            if (cf_req) begin
                if (n_req > 0) check(cf_target == target_seen, "cf_target moved during request");
                n_req++;
                target_seen = cf_target;
                trap_seen   = trap_cpu;
                cause_seen  = trap_cause;
            end
            if (dmem_ack) n_ack_cyc++;
            if (exec_mret) begin
                n_mret++;
                check(!s4_busy, "exec_mret high outside the progress cycle");
            end
            done = !s4_busy;
            cyc++;
            if (!done && cyc >= TIMEOUT) begin
                $display("Timeout: instruction still stalled after %0d cycles", TIMEOUT);
                timed_out = 1'b1;
                done      = 1'b1;
            end
            @(negedge g_clk);
        end
        n_cyc = cyc;
        idle_inputs();
    endtask

    // ------------------------------
    // Test sequence
    initial begin
        rnd = $urandom(32'h4d3b35c9);   // Seed once
        errors = 0;
        tests = 0;
        test_errs = 0;
        timed_out = 1'b0;
        g_clk = 1'b0;
        g_resetn = 1'b0;
        idle_inputs();
        s4_rd = '0;
        s4_opr_a = '0;
        s4_opr_b = '0;
        s4_uop = '0;
        s4_size = '0;
        dmem_error = 1'b0;
        dmem_rdata = '0;
        csr_rdata = '0;
        csr_mepc = $urandom() & 32'hffff_fffe;
        csr_mtvec = $urandom() & 32'hffff_fffc;
        repeat (5) @(negedge g_clk);
        g_resetn = 1'b1;
        model_pc = `PC_RESET;
        #1;
        check(trap_pc == `PC_RESET, "PC not at reset value");
        check(!cf_req && !csr_en && !dmem_ack && !gpr_wen, "outputs active while idle");
        end_test("reset");
        @(negedge g_clk);

        for (int i = 0; i < 6; i++) begin
            a = $urandom();
            b = $urandom();
            rnd = $urandom();
            run_op(fu_bit((i % 2 == 1) ? `FU_MUL : `FU_ALU), rnd[4:0], a, b, 1'b0, -1, -1);
            check(n_cyc == 1, "ALU/MUL result stalled the stage");
            check(n_wen == 1 && wdata_seen == a && rd_seen == rd_used, "wrong ALU/MUL write");
            step_pc();
        end
        ack = $urandom_range(0, 4);
        a = $urandom();
        run_op(fu_bit(`FU_ALU), 5'd0, a, b, 1'b1, -1, ack);
        check(n_cyc == ack + 1 && n_wen == 0, "decode trap wrote the GPR or misstalled");
        check(target_seen == csr_mtvec && trap_seen, "decode trap missed mtvec");
        check(cause_seen == a[5:0], "wrong decode trap cause");
        model_pc = csr_mtvec;
        end_test("alu_mul");

        for (int i = 0; i < 8; i++) begin
            a = $urandom();
            b = $urandom();
            rnd = $urandom();
            uop = {1'b0, rnd[3:0]};
            csr_rdata = $urandom();
            run_op(fu_bit(`FU_CSR), uop, a, b, 1'b0, -1, -1);
            check(n_cyc == 1 && n_csr_en == 1, "CSR access not single-cycle");
            check(csr_flags_seen == uop[3:1], "CSR flags do not follow the micro-op");
            check(csr_addr_seen == b[11:0] && csr_wdata_seen == a, "wrong CSR address or data");
            check(n_wen == (uop[0] ? 1 : 0), "CSR read write-enable wrong");
            if (uop[0]) check(wdata_seen == csr_rdata, "CSR read data not written");
            step_pc();
        end
        end_test("csr");

        for (int i = 0; i < 8; i++) begin
            case (i % 4)
                0: uop = `CFU_JAL;
                1: uop = `CFU_JALR;
                2: uop = `CFU_BRANCH_TAKEN;
                default: uop = 5'd0;      // Branch not taken
            endcase
            a = $urandom() & 32'hffff_fffe;
            ack = $urandom_range(0, 4);
            run_op(fu_bit(`FU_CFU), uop, a, b, 1'b0, -1, (uop != 5'd0) ? ack : -1);
            if (uop != 5'd0) begin
                check(n_cyc == ack + 1 && n_req == ack + 1, "jump request timing wrong");
                check(target_seen == a && !trap_seen, "wrong jump target");
            end else begin
                check(n_cyc == 1 && n_req == 0, "not-taken branch requested a change");
            end
            if (uop == `CFU_JAL || uop == `CFU_JALR)
                check(n_wen == 1 && wdata_seen == model_pc + size_used + size_used,
                      "wrong link value");
            else
                check(n_wen == 0, "branch wrote the GPR");
            if (uop != 5'd0)
                model_pc = a;
            else
                step_pc();
        end
        end_test("jumps");

        for (int i = 0; i < 3; i++) begin
            uop = (i == 0) ? `CFU_ECALL : (i == 1) ? `CFU_EBREAK : `CFU_MRET;
            ack = $urandom_range(0, 4);
            run_op(fu_bit(`FU_CFU), uop, $urandom(), b, 1'b0, -1, ack);
            check(n_cyc == ack + 1 && n_req == ack + 1 && n_wen == 0, "system op timing wrong");
            if (uop == `CFU_MRET) begin
                check(target_seen == csr_mepc && !trap_seen, "MRET target wrong");
                check(n_mret == 1, "exec_mret not seen once");
                model_pc = csr_mepc;
            end else begin
                check(target_seen == csr_mtvec && trap_seen, "system trap missed mtvec");
                check(cause_seen == ((uop == `CFU_ECALL) ? `TRAP_ECALL_M : `TRAP_BREAKPOINT),
                      "wrong system trap cause");
                check(n_mret == 0, "exec_mret high for a system trap");
                model_pc = csr_mtvec;
            end
        end
        end_test("system");

        for (int i = 0; i < 13; i++) begin
            sz = (i % 3 == 0) ? 2'd1 : (i % 3 == 1) ? 2'd2 : 2'd3;
            uop = (i == 12) ? {2'b10, 2'd3, 1'b0} : {2'b01, sz, (i >= 6)};
            b = $urandom();
            dmem_rdata = $urandom();
            recv = $urandom_range(0, 4);
            run_op(fu_bit(`FU_LSU), uop, a, b, 1'b0, recv, -1);
            check(n_cyc == recv + 1 && n_ack_cyc == recv + 1, "memory handshake timing wrong");
            check(n_req == 0, "good access requested a change");
            if (uop[`LSU_LOAD])
                check(n_wen == 1 && wdata_seen == load_value(uop, b, dmem_rdata),
                      "wrong load data");
            else
                check(n_wen == 0, "store wrote the GPR");
            step_pc();
        end
        end_test("loads");

        dmem_error = 1'b1;
        for (int i = 0; i < 2; i++) begin
            uop = (i == 0) ? {2'b01, 2'd3, 1'b0} : {2'b10, 2'd3, 1'b0};
            recv = $urandom_range(0, 4);
            ack = $urandom_range(0, 4);
            run_op(fu_bit(`FU_LSU), uop, a, $urandom(), 1'b0, recv, recv + ack);
            check(n_cyc == recv + ack + 1 && n_ack_cyc == recv + 1, "bus error timing wrong");
            check(n_wen == 0 && n_req == ack + 1, "bus error wrote the GPR");
            check(target_seen == csr_mtvec && trap_seen, "bus error missed mtvec");
            check(cause_seen == ((i == 0) ? `TRAP_LOAD_ACCESS : `TRAP_STORE_ACCESS),
                  "wrong bus error cause");
            model_pc = csr_mtvec;
        end
        dmem_error = 1'b0;
        end_test("bus_err");

        #1;
        check(trap_pc == model_pc, "final PC differs from model");
        $display("Tests run: %0d, errors: %0d", tests, errors);
        if (errors == 0 && !timed_out) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

/* flist.f */
+incdir+.
wb_pkg.sv
wb_op_if.sv
wb_csr_unit.sv
wb_cfu_unit.sv
wb_lsu_unit.sv
wb_stage.sv
tb_wb_stage.sv

/* Makefile */
# Verilator build and run of the writeback stage testbench

TOP = tb_wb_stage
LOG = sim.log

all: run

run:
	verilator --binary --timing --assert -f flist.f --top-module $(TOP) -o $(TOP)
	./obj_dir/$(TOP) | tee $(LOG)
	grep -q "ALL CHECKS PASSED" $(LOG)

lint:
	verilator --lint-only --timing -f flist.f --top-module wb_stage

clean:
	rm -rf obj_dir $(LOG)

.PHONY: all run lint clean
